/* program_input.txt */
# word count then program words (hex); trace count then pc wnum wdata name (hex hex hex text)
29
3c011234
34215678
2402ffff
24030005
00232021
00622823
00853024
00653825
00224026
0043482a
0043502b
00035900
00026702
3c0d8000
ada10100
3c0ea000
8dcf0100
24000055
00038021
11e10001
24110bad
15e10001
14620001
24110bad
10620001
0bf0001b
24110bad
24120022
0bf0001c
18
bfc00000 01 12340000 lui
bfc00004 01 12345678 ori
bfc00008 02 ffffffff addiu_neg
bfc0000c 03 00000005 addiu
bfc00010 04 1234567d addu
bfc00014 05 00000006 subu
bfc00018 06 00000004 and
bfc0001c 07 00000007 or
bfc00020 08 edcba987 xor
bfc00024 09 00000001 slt
bfc00028 0a 00000000 sltu
bfc0002c 0b 00000050 sll
bfc00030 0c 0000000f srl
bfc00034 0d 80000000 lui_kseg0
bfc0003c 0e a0000000 lui_kseg1
bfc00040 0f 12345678 lw_alias
bfc00048 10 00000005 read_r0
bfc0006c 12 00000022 jump_target

/* files.f */
mips_isa_pkg.sv
cpu_core_pkg.sv
regfile.sv
alu.sv
decoder.sv
mmu.sv
datapath.sv
mycpu_top.sv
mycpu_checker.sv
tb_trace_monitor.sv
tb_mycpu_top.sv

/* tb_mycpu_top.sv */
module tb_mycpu_top;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_wen;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // word arrays indexed by physical bits 11:2
    logic [31:0] imem [1024];
    logic [31:0] dmem [1024];
    int          n_trace;
    logic        load_ok;

    mycpu_top uut (.*);

    tb_trace_monitor monitor (.*);

    bind mycpu_top mycpu_checker protocol_check (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one-cycle read latency on both ports
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= imem[inst_sram_addr[11:2]];
        end
    end

    // whole-word stores only in this core
    always @(posedge clk) begin
        if (data_sram_en) begin
            if (data_sram_wen != 4'h0) begin
                dmem[data_sram_addr[11:2]] <= data_sram_wdata;
            end
            data_sram_rdata <= dmem[data_sram_addr[11:2]];
        end
    end

    // program image into imem, expected trace into the monitor
    task automatic load_input();
        int            fd;
        int            count;
        int            code;
        int            fields;
        logic [1023:0] header;
        logic [31:0]   word;
        logic [31:0]   pc;
        logic [31:0]   wnum;
        logic [31:0]   wdata;
        logic [127:0]  name;
        load_ok = 1'b0;
        n_trace = 0;
        count = 0;
        fd = $fopen("program_input.txt", "r");
        if (fd == 0) begin
            $display("could not open program_input.txt");
            return;
        end
        code = $fgets(header, fd);
        // header line counts as one field
        fields = (code > 0) ? 1 : 0;
        code = $fscanf(fd, "%d", count);
        fields += code;
        for (int i = 0; i < count; i++) begin
            code = $fscanf(fd, "%h", word);
            fields += code;
            imem[i] = word;
        end
        code = $fscanf(fd, "%d", n_trace);
        fields += code;
        for (int i = 0; i < n_trace; i++) begin
            code = $fscanf(fd, "%h %h %h %s", pc, wnum, wdata, name);
            fields += code;
            monitor.add_expected(pc, wnum[4:0], wdata, name);
        end
        $fclose(fd);
        load_ok = (count > 0) && (n_trace > 0) && (fields == 3 + count + 4 * n_trace);
        if (!load_ok) begin
            $display("program_input.txt is incomplete or holds no program or no expected trace");
        end
    endtask

    initial begin
        int   waited;
        int   entry;
        logic stalled;
        rst = 1'b1;
        inst_sram_rdata = 32'd0;
        data_sram_rdata = 32'd0;
        stalled = 1'b0;
        // unused words decode as sll $0, data words carry their index
        for (int i = 0; i < 1024; i++) begin
            imem[i] = 32'd0;
            dmem[i] = {~i[15:0], i[15:0]};
        end
        load_input();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // each retirement must show up within 20 cycles
        entry = 0;
        while (load_ok && !stalled && entry < n_trace) begin
            waited = 0;
            while (monitor.n_seen <= entry && waited < 20) begin
                @(negedge clk);
                waited++;
            end
            if (monitor.n_seen <= entry) begin
                $display("core stopped retiring at trace entry %0d", entry);
                stalled = 1'b1;
            end
            entry++;
        end
        $display("tests passed %0d failed %0d, assertion failures %0d",
                 monitor.n_pass, monitor.n_fail, uut.protocol_check.n_errors);
        if (!load_ok || stalled || monitor.n_fail != 0 || uut.protocol_check.n_errors != 0) begin
            $display("Checks failed");
        end else begin
            $display("All checks passed");
        end
        $finish;
    end

endmodule

/* tb_trace_monitor.sv */
module tb_trace_monitor (
    input logic        clk,
    input logic        rst,
    input logic [31:0] inst_sram_addr,
    input logic [31:0] inst_sram_rdata,
    input logic        data_sram_en,
    input logic [31:0] data_sram_addr,
    input logic [31:0] debug_wb_pc,
    input logic [3:0]  debug_wb_rf_wen,
    input logic [4:0]  debug_wb_rf_wnum,
    input logic [31:0] debug_wb_rf_wdata
);
    timeunit 1ns;
    timeprecision 1ps;
    import mips_isa_pkg::*;

    // boot address 0xBFC0_0000 with the kseg1 bits cleared
    localparam logic [31:0] boot_paddr = 32'h1FC0_0000;

    logic [31:0]  exp_pc [64];
    logic [4:0]   exp_wnum [64];
    logic [31:0]  exp_wdata [64];
    logic [127:0] exp_name [64];
    int           n_expected = 0;
    int           n_seen = 0;
    int           n_pass = 0;
    int           n_fail = 0;
    logic         first_fetch = 1'b1;
    // current instruction, its word and cycles spent so far
    logic [31:0]  run_pc;
    logic [31:0]  run_word;
    int           run_len = 0;

    task automatic add_expected(input logic [31:0] pc, input logic [4:0] wnum,
                                input logic [31:0] wdata, input logic [127:0] name);
        exp_pc[n_expected] = pc;
        exp_wnum[n_expected] = wnum;
        exp_wdata[n_expected] = wdata;
        exp_name[n_expected] = name;
        n_expected++;
    endtask

    // alu, branch, jump 3 cycles, store 4, load 5
    function automatic int class_cycles(input logic [31:0] word);
        case (word[31:26])
            OP_LW:   return 5;
            OP_SW:   return 4;
            default: return 3;
        endcase
    endfunction

    task automatic tally(input logic ok, input string name,
                         input logic [31:0] expected, input logic [31:0] actual);
        if (ok) begin
            n_pass++;
            $display("PASS %0s value %h", name, actual);
        end else begin
            n_fail++;
            $display("CHECK FAILED %0s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_retire();
        int i;
        i = n_seen;
        if (i >= n_expected) begin
            n_fail++;
            $display("retirement at pc %h is beyond the expected trace", debug_wb_pc);
        end else if (debug_wb_pc === exp_pc[i] && debug_wb_rf_wnum === exp_wnum[i]
                     && debug_wb_rf_wdata === exp_wdata[i] && debug_wb_rf_wen === 4'hF) begin
            n_pass++;
            $display("PASS %0s pc %h r%0d = %h", exp_name[i], debug_wb_pc,
                     debug_wb_rf_wnum, debug_wb_rf_wdata);
        end else begin
            n_fail++;
            $display("CHECK FAILED %0s expected pc %h r%0d %h actual pc %h r%0d %h wen %h",
                     exp_name[i], exp_pc[i], exp_wnum[i], exp_wdata[i], debug_wb_pc,
                     debug_wb_rf_wnum, debug_wb_rf_wdata, debug_wb_rf_wen);
        end
        n_seen++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            run_pc = debug_wb_pc;
            run_len = 0;
        end else begin
            if (first_fetch) begin
                tally(inst_sram_addr === boot_paddr, "fetch_map", boot_paddr, inst_sram_addr);
                first_fetch = 1'b0;
            end
            // segment bits gone before the data sram
            if (data_sram_en) begin
                tally(data_sram_addr[31:29] === 3'b000, "dmem_map", 32'd0,
                      {29'd0, data_sram_addr[31:29]});
            end
            // pc only moves on a retirement
            if (debug_wb_pc !== run_pc) begin
                if (run_len > 0) begin
                    tally(run_len == class_cycles(run_word), $sformatf("spacing_%h", run_pc),
                          class_cycles(run_word), run_len);
                end
                run_pc = debug_wb_pc;
                run_len = 0;
            end
            run_len++;
            // last sample of the run holds the fetched word
            run_word = inst_sram_rdata;
            if (debug_wb_rf_wen != 4'h0) begin
                check_retire();
            end
        end
    end

endmodule

/* mycpu_checker.sv */
module mycpu_checker (
    input logic        clk,
    input logic        rst,
    input logic [3:0]  inst_sram_wen,
    input logic [31:0] inst_sram_addr,
    input logic [31:0] inst_sram_wdata,
    input logic        data_sram_en,
    input logic [3:0]  data_sram_wen,
    input logic [3:0]  debug_wb_rf_wen
);
    timeunit 1ns;
    timeprecision 1ps;

    int n_errors = 0;

    // fetch port is read only
    inst_read_only: assert property (@(posedge clk)
        inst_sram_wen == 4'h0 && inst_sram_wdata == 32'd0)
        else begin
            n_errors++;
            $error("inst_sram_wen or inst_sram_wdata raised");
        end

    // store strobes need the enable
    data_wen_needs_en: assert property (@(posedge clk) (data_sram_wen != 4'h0) |-> data_sram_en)
        else begin
            n_errors++;
            $error("data_sram_wen without data_sram_en");
        end

    // state settles after the first reset edge
    no_trace_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> debug_wb_rf_wen == 4'h0)
        else begin
            n_errors++;
            $error("debug_wb_rf_wen raised during reset");
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (rst) inst_sram_addr[1:0] == 2'b00)
        else begin
            n_errors++;
            $error("inst_sram_addr not word aligned");
        end

endmodule

/* mycpu_top.sv */
module mycpu_top (
    input  logic        clk,
    input  logic        rst,

    // instruction sram
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_wen,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,

    // data sram
    output logic        data_sram_en,
    output logic [3:0]  data_sram_wen,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,

    // retirement trace
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import cpu_core_pkg::*;

    logic [31:0] pc;
    mem_req_t    data_req;
    wb_trace_t   trace;
    logic [31:0] inst_paddr;
    logic [31:0] data_paddr;

    datapath datapath (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .instr      (inst_sram_rdata),
        .data_req   (data_req),
        .data_rdata (data_sram_rdata),
        .trace      (trace)
    );

    // both address streams go through the fixed mapping
    mmu mmu (
        .inst_vaddr (pc),
        .inst_paddr (inst_paddr),
        .data_vaddr (data_req.addr),
        .data_paddr (data_paddr)
    );

    // fetch port always reading
    assign inst_sram_en = 1'b1;
    assign inst_sram_wen = 4'h0;
    assign inst_sram_addr = inst_paddr;
    assign inst_sram_wdata = 32'd0;

    assign data_sram_en = data_req.en;
    assign data_sram_wen = data_req.wen;
    assign data_sram_addr = data_paddr;
    assign data_sram_wdata = data_req.wdata;

    // flatten trace struct
    assign debug_wb_pc = trace.pc;
    assign debug_wb_rf_wen = trace.wen;
    assign debug_wb_rf_wnum = trace.wnum;
    assign debug_wb_rf_wdata = trace.wdata;

endmodule

/* datapath.sv */
module datapath (
    input  logic                    clk,
    input  logic                    rst,
    output logic [31:0]             pc,
    input  mips_isa_pkg::instr_t    instr,
    output cpu_core_pkg::mem_req_t  data_req,
    input  logic [31:0]             data_rdata,
    output cpu_core_pkg::wb_trace_t trace
);
    import mips_isa_pkg::*;
    import cpu_core_pkg::*;

    cpu_state_e  state;
    instr_t      ir;
    ctrl_t       ctrl;
    logic [31:0] a_reg;
    logic [31:0] b_reg;
    logic [31:0] alu_out_reg;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] ext_imm;
    logic [31:0] alu_b;
    logic [4:0]  alu_shamt;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic        taken;
    logic [31:0] pc_plus4;
    logic [31:0] branch_target;
    logic [31:0] jump_target;
    logic [31:0] next_pc;
    logic        retire;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    // operands read straight off the sram word during DECODE
    regfile regfile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (instr.rs),
        .raddr2 (instr.rt),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    decoder decoder (
        .instr (ir),
        .ctrl  (ctrl)
    );

    // imm is the low half of the latched word
    assign ext_imm = ctrl.zero_ext ? {16'd0, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
    assign alu_b = ctrl.imm_sel ? ext_imm : b_reg;
    assign alu_shamt = ctrl.use_shamt ? ir.shamt : 5'd0;

    alu alu (
        .op     (ctrl.alu_op),
        .a      (a_reg),
        .b      (alu_b),
        .shamt  (alu_shamt),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // no delay slot, redirect straight away
    assign pc_plus4 = pc + 32'd4;
    assign branch_target = pc_plus4 + {ext_imm[29:0], 2'b00};
    assign jump_target = {pc[31:28], ir[25:0], 2'b00};
    assign taken = (ctrl.is_beq && alu_zero) || (ctrl.is_bne && !alu_zero);

    always_comb begin
        if (ctrl.is_jump) begin
            next_pc = jump_target;
        end else if (taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // retire points: 3 cycles alu/branch, 4 store, 5 load
    assign retire = (state == EXECUTE && !ctrl.is_load && !ctrl.is_store)
                 || (state == MEM && ctrl.is_store)
                 || (state == WRITEBACK);

    assign rf_we = retire && ctrl.reg_write;
    assign rf_waddr = ctrl.dest_rt ? ir.rt : ir.rd;
    // load data only in WRITEBACK
    assign rf_wdata = (state == WRITEBACK) ? data_rdata : alu_result;

    // control state and pc
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH;
            pc <= reset_vector;
        end else begin
            case (state)
                FETCH:     state <= DECODE;
                DECODE:    state <= EXECUTE;
                EXECUTE: begin
                    if (ctrl.is_load || ctrl.is_store) begin
                        state <= MEM;
                    end else begin
                        state <= FETCH;
                    end
                end
                MEM:       state <= ctrl.is_load ? WRITEBACK : FETCH;
                WRITEBACK: state <= FETCH;
                default:   state <= FETCH;
            endcase
            // pc holds the retiring address until the last cycle
            if (retire) begin
                pc <= next_pc;
            end
        end
    end

    // instruction and operand latches
    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            ir <= instr;
            a_reg <= rdata1;
            b_reg <= rdata2;
        end
        // effective address for MEM
        if (state == EXECUTE) begin
            alu_out_reg <= alu_result;
        end
    end

    // one-cycle data access in MEM
    assign data_req.en = (state == MEM);
    assign data_req.wen = (state == MEM && ctrl.is_store) ? 4'hF : 4'h0;
    assign data_req.addr = alu_out_reg;
    assign data_req.wdata = b_reg;

    // wen only for a real register write
    assign trace.pc = pc;
    assign trace.wen = (rf_we && rf_waddr != 5'd0) ? 4'hF : 4'h0;
    assign trace.wnum = rf_waddr;
    assign trace.wdata = rf_wdata;

endmodule

/* mmu.sv */
module mmu (
    input  logic [31:0] inst_vaddr,
    output logic [31:0] inst_paddr,
    input  logic [31:0] data_vaddr,
    output logic [31:0] data_paddr
);

    // kseg0/kseg1 drop the top three bits, useg and kseg2/3 pass through
    function automatic logic [31:0] translate(input logic [31:0] vaddr);
        logic in_kseg;
        in_kseg = (vaddr[31:30] == 2'b10);
        if (in_kseg) begin
            return {3'b000, vaddr[28:0]};
        end
        return vaddr;
    endfunction

    // fetch side
    assign inst_paddr = translate(inst_vaddr);
    // load/store side
    assign data_paddr = translate(data_vaddr);

endmodule

/* decoder.sv */
module decoder (
    input  mips_isa_pkg::instr_t instr,
    output cpu_core_pkg::ctrl_t  ctrl
);
    import mips_isa_pkg::*;
    import cpu_core_pkg::*;

    always_comb begin
        // unsupported encodings fall out as nop
        ctrl = '0;
        ctrl.alu_op = ALU_ADD;
        case (instr.op)
            OP_SPECIAL: begin
                ctrl.reg_write = 1'b1;
                case (instr.funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLTU: ctrl.alu_op = ALU_SLTU;
                    FN_SLL: begin
                        ctrl.alu_op = ALU_SLL;
                        ctrl.use_shamt = 1'b1;
                    end
                    FN_SRL: begin
                        ctrl.alu_op = ALU_SRL;
                        ctrl.use_shamt = 1'b1;
                    end
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            // immediates write rt
            OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI: begin
                ctrl.imm_sel = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest_rt = 1'b1;
                // logical imms are zero extended
                ctrl.zero_ext = (instr.op == OP_ANDI) || (instr.op == OP_ORI);
                if (instr.op == OP_ANDI) begin
                    ctrl.alu_op = ALU_AND;
                end else if (instr.op == OP_ORI) begin
                    ctrl.alu_op = ALU_OR;
                end else if (instr.op == OP_LUI) begin
                    ctrl.alu_op = ALU_LUI;
                end
            end
            // address = base + sext(imm)
            OP_LW: begin
                ctrl.imm_sel = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest_rt = 1'b1;
                ctrl.is_load = 1'b1;
            end
            OP_SW: begin
                ctrl.imm_sel = 1'b1;
                ctrl.is_store = 1'b1;
            end
            // compare by subtraction
            OP_BEQ: begin
                ctrl.alu_op = ALU_SUB;
                ctrl.is_beq = 1'b1;
            end
            OP_BNE: begin
                ctrl.alu_op = ALU_SUB;
                ctrl.is_bne = 1'b1;
            end
            OP_J: ctrl.is_jump = 1'b1;
            default: ctrl.reg_write = 1'b0;
        endcase
    end

endmodule

/* alu.sv */
module alu (
    input  cpu_core_pkg::alu_op_e op,
    input  logic [31:0]           a,
    input  logic [31:0]           b,
    input  logic [4:0]            shamt,
    output logic [31:0]           result,
    output logic                  zero
);
    import cpu_core_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            // signed compare
            ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'd0, a < b};
            // shifts act on rt, which sits on b
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            // imm into upper half
            ALU_LUI:  result = {b[15:0], 16'd0};
            default:  result = 32'd0;
        endcase
    end

    // beq/bne resolve on this
    assign zero = (result == 32'd0);

endmodule

/* regfile.sv */
module regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    // sync write, $0 never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // async read, $0 forced to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

/* cpu_core_pkg.sv */
package cpu_core_pkg;

    // first fetch address, kseg1 boot rom
    localparam logic [31:0] reset_vector = 32'hBFC0_0000;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEM,
        WRITEBACK
    } cpu_state_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    // decoder output
    typedef struct packed {
        alu_op_e alu_op;
        // operand b from immediate
        logic    imm_sel;
        logic    zero_ext;
        logic    reg_write;
        // rt is the destination, not rd
        logic    dest_rt;
        logic    is_load;
        logic    is_store;
        logic    is_beq;
        logic    is_bne;
        logic    is_jump;
        logic    use_shamt;
    } ctrl_t;

    typedef struct packed {
        logic        en;
        logic [3:0]  wen;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [3:0]  wen;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } wb_trace_t;

endpackage

/* mips_isa_pkg.sv */
package mips_isa_pkg;

    // major opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    // funct field for the SPECIAL group
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_e;

    // R-type layout, imm and jump target overlap the low bits
    typedef struct packed {
        opcode_e    op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } instr_t;

endpackage
